//--- common/front_end_pkg.sv
/*
  shared constants and types of the instruction front end
  OR1K field layout, only l.j and l.nop are told apart from other opcodes
  reset and exception vectors are fixed, no relocation register
*/
`default_nettype none

package front_end_pkg;

   // datapath widths
   localparam int ADDR_W    = 32;
   localparam int INSN_W    = 32;
   localparam int RF_ADDR_W = 5;

   // first fetch after reset and the ibus error redirect
   localparam logic [ADDR_W-1:0] RESET_PC   = 32'h0000_0100;
   localparam logic [ADDR_W-1:0] EXCEPT_VEC = 32'h0000_0200;

   // instruction field positions
   localparam int OPC_W    = 6;
   localparam int OPC_LSB  = 26;
   localparam int RA_LSB   = 16;
   localparam int RB_LSB   = 11;
   // jump offset, sign extended and shifted left by two
   localparam int OFFSET_W = 26;

   // major opcodes that decode cares about
   localparam logic [OPC_W-1:0] MAJOR_J   = 6'h00;
   localparam logic [OPC_W-1:0] MAJOR_NOP = 6'h05;

   // l.nop 0, fills decode after reset or an exception
   localparam logic [INSN_W-1:0] NOP_WORD = 32'h1500_0000;

   // opcode class as seen by control and the issue port
   typedef enum logic [1:0] {
      OP_NOP,
      OP_J,
      OP_OTHER
   } opcode_e;

   // pipeline control states
   typedef enum logic [1:0] {
      RUN,
      DELAY_SLOT,
      REDIRECT,
      EXCEPT
   } ctrl_state_e;

endpackage

`default_nettype wire

//--- fetch/fetch_unit.sv
/*
  fetch unit with a single instruction buffer
  a new access starts only once the buffer is empty or being consumed
  redirects are expected while no ibus access is outstanding
  after a bus error no request is made until the next redirect
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
   input  wire                                 clk,
   input  wire                                 rst,
   // instruction bus
   output logic                                ibus_req_o,
   output logic [front_end_pkg::ADDR_W-1:0]    ibus_adr_o,
   input  wire                                 ibus_ack_i,
   input  wire                                 ibus_err_i,
   input  wire  [front_end_pkg::INSN_W-1:0]    ibus_dat_i,
   // from pipeline control
   input  wire                                 padv_i,
   input  wire                                 redirect_i,
   input  wire  [front_end_pkg::ADDR_W-1:0]    redirect_pc_i,
   input  wire                                 hold_i,
   // to pipeline control
   output logic                                fetch_done_o,
   output logic [front_end_pkg::ADDR_W-1:0]    fetch_pc_o,
   output logic                                fetch_err_o,
   // to decode
   output logic [front_end_pkg::INSN_W-1:0]    insn_word_o,
   output logic [front_end_pkg::ADDR_W-1:0]    insn_pc_o
);

   // fetch address and request flag
   logic [front_end_pkg::ADDR_W-1:0] pc_q;
   logic                             req_q;
   // one-entry buffer, valid flag and bus error flag
   logic                             buf_valid_q;
   logic                             buf_err_q;
   logic [front_end_pkg::INSN_W-1:0] buf_word_q;
   logic [front_end_pkg::ADDR_W-1:0] buf_pc_q;
   // set on a bus error, waits for the exception redirect
   logic                             err_wait_q;

   logic                             access_done;
   logic                             start_req;

   // an ack or err in the redirect cycle belongs to the old stream, drop it
   assign access_done = req_q & (ibus_ack_i | ibus_err_i) & ~redirect_i;

   // new access when the buffer is free or leaves this cycle
   // not while downstream is stalled and not after a bus error
   assign start_req = ~req_q & (~buf_valid_q | padv_i) & ~hold_i &
                      ~err_wait_q & ~redirect_i;

   assign ibus_req_o = req_q;
   assign ibus_adr_o = pc_q;

   assign fetch_done_o = buf_valid_q;
   assign fetch_err_o  = buf_err_q;
   assign fetch_pc_o   = buf_pc_q;

   // decode picks the buffer up on padv
   assign insn_word_o = buf_word_q;
   assign insn_pc_o   = buf_pc_q;

   // fetch PC
   always_ff @(posedge clk)
   begin
      if (rst)
         pc_q <= front_end_pkg::RESET_PC;
      else if (redirect_i)
         pc_q <= redirect_pc_i;
      else if (access_done)
         pc_q <= pc_q + front_end_pkg::ADDR_W'(4);
   end

   // request stays up with a stable address until ack or err
   always_ff @(posedge clk)
   begin
      if (rst)
         req_q <= 1'b0;
      else if (redirect_i)
         // low for at least the cycle after any redirect
         req_q <= 1'b0;
      else if (access_done)
         req_q <= 1'b0;
      else if (start_req)
         req_q <= 1'b1;
   end

   // buffer flags
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         buf_valid_q <= 1'b0;
         buf_err_q   <= 1'b0;
      end
      else if (redirect_i)
      begin
         buf_valid_q <= 1'b0;
         buf_err_q   <= 1'b0;
      end
      else if (access_done)
      begin
         buf_valid_q <= 1'b1;
         buf_err_q   <= ibus_err_i;
      end
      else if (padv_i)
         buf_valid_q <= 1'b0;
   end

   // buffer payload, a faulting access leaves a nop behind
   always_ff @(posedge clk)
   begin
      if (access_done)
      begin
         buf_pc_q   <= pc_q;
         buf_word_q <= ibus_err_i ? front_end_pkg::NOP_WORD : ibus_dat_i;
      end
   end

   // no more requests after a bus error until the redirect arrives
   always_ff @(posedge clk)
   begin
      if (rst)
         err_wait_q <= 1'b0;
      else if (redirect_i)
         err_wait_q <= 1'b0;
      else if (access_done & ibus_err_i)
         err_wait_q <= 1'b1;
   end

endmodule

`default_nettype wire

//--- logic/insn_decode.sv
/*
  registered decode stage, loads the fetch buffer on padv
  dec_valid_o is a one-cycle pulse, outputs hold until the next padv
  only l.j gets a jump target, no conditional branches
*/
`timescale 1ns/100ps
`default_nettype none

module insn_decode (
   input  wire                                    clk,
   input  wire                                    rst,
   input  wire                                    padv_i,
   input  wire                                    flush_i,
   input  wire  [front_end_pkg::INSN_W-1:0]       insn_word_i,
   input  wire  [front_end_pkg::ADDR_W-1:0]       insn_pc_i,
   output logic                                   dec_valid_o,
   output front_end_pkg::opcode_e                 dec_op_o,
   output logic [front_end_pkg::ADDR_W-1:0]       dec_pc_o,
   output logic [front_end_pkg::INSN_W-1:0]       dec_insn_o,
   output logic [front_end_pkg::RF_ADDR_W-1:0]    dec_rfa_o,
   output logic [front_end_pkg::RF_ADDR_W-1:0]    dec_rfb_o,
   output logic [front_end_pkg::ADDR_W-1:0]       dec_target_o
);

   logic [front_end_pkg::OPC_W-1:0]    major;
   logic [front_end_pkg::OFFSET_W-1:0] offset;
   logic [front_end_pkg::ADDR_W-1:0]   offset_ext;
   front_end_pkg::opcode_e             op_next;

   assign major  = insn_word_i[front_end_pkg::OPC_LSB +: front_end_pkg::OPC_W];
   assign offset = insn_word_i[front_end_pkg::OFFSET_W-1:0];

   // word offset to byte offset, sign filled to the address width
   assign offset_ext = {{(front_end_pkg::ADDR_W - front_end_pkg::OFFSET_W - 2)
                        {offset[front_end_pkg::OFFSET_W-1]}}, offset, 2'b00};

   // opcode class
   always_comb
   begin
      case (major)
         front_end_pkg::MAJOR_J:   op_next = front_end_pkg::OP_J;
         front_end_pkg::MAJOR_NOP: op_next = front_end_pkg::OP_NOP;
         default:                  op_next = front_end_pkg::OP_OTHER;
      endcase
   end

   // valid, word and class; flush puts a nop back in
   always_ff @(posedge clk)
   begin
      if (rst | flush_i)
      begin
         dec_valid_o <= 1'b0;
         dec_insn_o  <= front_end_pkg::NOP_WORD;
         dec_op_o    <= front_end_pkg::OP_NOP;
      end
      else
      begin
         dec_valid_o <= padv_i;
         if (padv_i)
         begin
            dec_insn_o <= insn_word_i;
            dec_op_o   <= op_next;
         end
      end
   end

   // pc, register fields and jump target, pc relative to the jump itself
   always_ff @(posedge clk)
   begin
      if (padv_i)
      begin
         dec_pc_o     <= insn_pc_i;
         dec_rfa_o    <= insn_word_i[front_end_pkg::RA_LSB +: front_end_pkg::RF_ADDR_W];
         dec_rfb_o    <= insn_word_i[front_end_pkg::RB_LSB +: front_end_pkg::RF_ADDR_W];
         dec_target_o <= insn_pc_i + offset_ext;
      end
   end

endmodule

`default_nettype wire

//--- logic/pipe_control.sv
/*
  pipeline control, issue register and jump / exception sequencing
  one delay slot after l.j, the redirect goes out with the slot's padv
  a faulting fetch is taken only once nothing older waits to issue
*/
`timescale 1ns/100ps
`default_nettype none

module pipe_control (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire                                 stall_i,
   // fetch side
   input  wire                                 fetch_done_i,
   input  wire  [front_end_pkg::ADDR_W-1:0]    fetch_pc_i,
   input  wire                                 fetch_err_i,
   output logic                                padv_o,
   output logic                                redirect_o,
   output logic [front_end_pkg::ADDR_W-1:0]    redirect_pc_o,
   output logic                                hold_o,
   // decode side
   input  wire                                 dec_valid_i,
   input  wire  front_end_pkg::opcode_e        dec_op_i,
   input  wire  [front_end_pkg::ADDR_W-1:0]    dec_pc_i,
   input  wire  [front_end_pkg::INSN_W-1:0]    dec_insn_i,
   input  wire  [front_end_pkg::ADDR_W-1:0]    dec_target_i,
   output logic                                flush_o,
   // issue and exception outputs
   output logic                                issue_valid_o,
   output logic [front_end_pkg::ADDR_W-1:0]    issue_pc_o,
   output logic [front_end_pkg::INSN_W-1:0]    issue_insn_o,
   output front_end_pkg::opcode_e              issue_op_o,
   output logic                                except_valid_o,
   output logic [front_end_pkg::ADDR_W-1:0]    except_pc_o
);

   front_end_pkg::ctrl_state_e       state_q;
   front_end_pkg::ctrl_state_e       state_d;
   logic [front_end_pkg::ADDR_W-1:0] target_q;
   // decoded item caught during a stall, goes out when it clears
   logic                             pend_q;
   logic                             padv;
   logic                             exc_take;
   logic                             jump_seen;
   logic                             issue_take;

   assign hold_o = stall_i;

   // consume the fetch buffer, never a faulting one
   assign padv   = fetch_done_i & ~fetch_err_i & ~stall_i &
                   (state_q != front_end_pkg::EXCEPT);
   assign padv_o = padv;

   // take the fault once the older instructions have left decode
   assign exc_take = fetch_done_i & fetch_err_i & ~stall_i & ~pend_q & ~dec_valid_i &
                     ((state_q == front_end_pkg::RUN) |
                      (state_q == front_end_pkg::DELAY_SLOT));

   // a jump that is itself a delay slot is not followed
   assign jump_seen = dec_valid_i & (dec_op_i == front_end_pkg::OP_J) &
                      (state_q == front_end_pkg::RUN);

   assign issue_take = (dec_valid_i | pend_q) & ~stall_i;

   // redirect with the delay slot's padv, or one cycle after a fault
   assign redirect_o = (state_q == front_end_pkg::EXCEPT) |
                       ((state_q == front_end_pkg::DELAY_SLOT) & padv);
   assign redirect_pc_o = (state_q == front_end_pkg::EXCEPT) ?
                          front_end_pkg::EXCEPT_VEC : target_q;
   assign flush_o = (state_q == front_end_pkg::EXCEPT);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         front_end_pkg::RUN:
            if (exc_take)
               state_d = front_end_pkg::EXCEPT;
            else if (jump_seen)
               state_d = front_end_pkg::DELAY_SLOT;
         front_end_pkg::DELAY_SLOT:
            // a faulting slot wins over the jump target
            if (exc_take)
               state_d = front_end_pkg::EXCEPT;
            else if (padv)
               state_d = front_end_pkg::REDIRECT;
         default:
            state_d = front_end_pkg::RUN;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q        <= front_end_pkg::RUN;
         pend_q         <= 1'b0;
         issue_valid_o  <= 1'b0;
         except_valid_o <= 1'b0;
      end
      else
      begin
         state_q        <= state_d;
         issue_valid_o  <= issue_take;
         except_valid_o <= exc_take;
         if (flush_o)
            pend_q <= 1'b0;
         else if (dec_valid_i & stall_i)
            pend_q <= 1'b1;
         else if (issue_take)
            pend_q <= 1'b0;
      end
   end

   // payload registers, decode holds its outputs over a stall
   always_ff @(posedge clk)
   begin
      if (jump_seen)
         target_q <= dec_target_i;
      if (issue_take)
      begin
         issue_pc_o   <= dec_pc_i;
         issue_insn_o <= dec_insn_i;
         issue_op_o   <= dec_op_i;
      end
      if (exc_take)
         except_pc_o <= fetch_pc_i;
   end

endmodule

`default_nettype wire

//--- logic/front_end_top.sv
/*
  instruction front end, fetch then decode then pipeline control
  issue and exception outputs are single-cycle strobes
  stall_i is a level and holds back new fetches and issue
*/
`timescale 1ns/100ps
`default_nettype none

module front_end_top (
   input  wire                                 clk,
   input  wire                                 rst,
   // instruction bus
   output logic                                ibus_req_o,
   output logic [front_end_pkg::ADDR_W-1:0]    ibus_adr_o,
   input  wire                                 ibus_ack_i,
   input  wire                                 ibus_err_i,
   input  wire  [front_end_pkg::INSN_W-1:0]    ibus_dat_i,
   // downstream
   input  wire                                 stall_i,
   output logic                                issue_valid_o,
   output logic [front_end_pkg::ADDR_W-1:0]    issue_pc_o,
   output logic [front_end_pkg::INSN_W-1:0]    issue_insn_o,
   output front_end_pkg::opcode_e              issue_op_o,
   output logic                                except_valid_o,
   output logic [front_end_pkg::ADDR_W-1:0]    except_pc_o
);

   // fetch and control
   logic                             fetch_done;
   logic [front_end_pkg::ADDR_W-1:0] fetch_pc;
   logic                             fetch_err;
   logic                             padv;
   logic                             redirect;
   logic [front_end_pkg::ADDR_W-1:0] redirect_pc;
   logic                             hold;
   // fetch buffer into decode
   logic [front_end_pkg::INSN_W-1:0] insn_word;
   logic [front_end_pkg::ADDR_W-1:0] insn_pc;
   // decode into control
   logic                             flush;
   logic                             dec_valid;
   front_end_pkg::opcode_e           dec_op;
   logic [front_end_pkg::ADDR_W-1:0] dec_pc;
   logic [front_end_pkg::INSN_W-1:0] dec_insn;
   logic [front_end_pkg::ADDR_W-1:0] dec_target;

   fetch_unit u_fetch (
      .clk(clk), .rst(rst),
      .ibus_req_o(ibus_req_o), .ibus_adr_o(ibus_adr_o), .ibus_ack_i(ibus_ack_i),
      .ibus_err_i(ibus_err_i), .ibus_dat_i(ibus_dat_i),
      .padv_i(padv), .redirect_i(redirect), .redirect_pc_i(redirect_pc), .hold_i(hold),
      .fetch_done_o(fetch_done), .fetch_pc_o(fetch_pc), .fetch_err_o(fetch_err),
      .insn_word_o(insn_word), .insn_pc_o(insn_pc)
   );

   // register fields go to the register file, not built here
   insn_decode u_decode (
      .clk(clk), .rst(rst), .padv_i(padv), .flush_i(flush),
      .insn_word_i(insn_word), .insn_pc_i(insn_pc),
      .dec_valid_o(dec_valid), .dec_op_o(dec_op), .dec_pc_o(dec_pc), .dec_insn_o(dec_insn),
      .dec_rfa_o(), .dec_rfb_o(), .dec_target_o(dec_target)
   );

   pipe_control u_ctrl (
      .clk(clk), .rst(rst), .stall_i(stall_i),
      .fetch_done_i(fetch_done), .fetch_pc_i(fetch_pc), .fetch_err_i(fetch_err),
      .padv_o(padv), .redirect_o(redirect), .redirect_pc_o(redirect_pc), .hold_o(hold),
      .dec_valid_i(dec_valid), .dec_op_i(dec_op), .dec_pc_i(dec_pc),
      .dec_insn_i(dec_insn), .dec_target_i(dec_target), .flush_o(flush),
      .issue_valid_o(issue_valid_o), .issue_pc_o(issue_pc_o),
      .issue_insn_o(issue_insn_o), .issue_op_o(issue_op_o),
      .except_valid_o(except_valid_o), .except_pc_o(except_pc_o)
   );

endmodule

`default_nettype wire

//--- tests/front_end_checker.sv
/*
  protocol assertions for the front end, bound into fetch_unit and pipe_control
  each bind ties off the ports that its side does not have
  needs a simulator with concurrent assertions switched on
*/
`timescale 1ns/100ps
`default_nettype none

module front_end_checker (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire                                 req_i,
   input  wire  [front_end_pkg::ADDR_W-1:0]    adr_i,
   input  wire                                 ack_i,
   input  wire                                 err_i,
   input  wire                                 redirect_i,
   input  wire                                 stall_i,
   input  wire                                 issue_valid_i,
   input  wire                                 except_valid_i,
   input  wire  front_end_pkg::ctrl_state_e    state_i
);

   // a pending request keeps its address until ack or err
   adr_stable_a: assert property (@(posedge clk) disable iff (rst)
      (req_i & ~ack_i & ~err_i & ~redirect_i) |=> (req_i & (adr_i == $past(adr_i))))
      else $error("ibus address moved while the request was pending");

   // issue register only loads in a cycle without stall
   no_stall_issue_a: assert property (@(posedge clk) disable iff (rst)
      issue_valid_i |-> !$past(stall_i))
      else $error("issue strobe from a stalled cycle");

   one_strobe_a: assert property (@(posedge clk) disable iff (rst)
      !(issue_valid_i & except_valid_i))
      else $error("issue and exception strobes high together");

   // request gap after jump and exception redirects
   req_gap_a: assert property (@(posedge clk) disable iff (rst)
      redirect_i |=> !req_i)
      else $error("ibus request high in the cycle after a redirect");

   // nothing older or younger issues behind the exception redirect
   except_drop_a: assert property (@(posedge clk) disable iff (rst)
      (state_i == front_end_pkg::EXCEPT) |=> !issue_valid_i)
      else $error("issue strobe right after the exception redirect");

endmodule

bind fetch_unit front_end_checker u_fetch_chk (
   .clk(clk), .rst(rst), .req_i(ibus_req_o), .adr_i(ibus_adr_o), .ack_i(ibus_ack_i),
   .err_i(ibus_err_i), .redirect_i(redirect_i), .stall_i(hold_i),
   .issue_valid_i(1'b0), .except_valid_i(1'b0), .state_i(front_end_pkg::RUN)
);

bind pipe_control front_end_checker u_ctrl_chk (
   .clk(clk), .rst(rst), .req_i(1'b0), .adr_i('0), .ack_i(1'b0), .err_i(1'b0),
   .redirect_i(redirect_o), .stall_i(stall_i), .issue_valid_i(issue_valid_o),
   .except_valid_i(except_valid_o), .state_i(state_q)
);

`default_nettype wire

//--- tests/tb_front_end.sv
/*
  directed tests for the instruction front end
  ibus slave models 1024 words at address bits 11:2, higher bits alias
  acknowledge latency is 1 to 3 cycles at random, or fixed per test
  expected issue order comes from a walk of the program, not from the DUT
*/
`timescale 1ns/100ps
`default_nettype none

module tb_front_end;

   // about 90 expected events, at most 5 cycles each at latency 3,
   // plus stall spans and 16-cycle resets, with wide margin
   localparam int MAX_CYCLES = 4000;

   logic                             clk;
   logic                             rst = 1'b1;
   logic                             stall = 1'b0;
   logic                             ibus_req;
   logic [front_end_pkg::ADDR_W-1:0] ibus_adr;
   logic                             ibus_ack = 1'b0;
   logic                             ibus_err = 1'b0;
   logic [front_end_pkg::INSN_W-1:0] ibus_dat = '0;
   logic                             issue_valid;
   logic [front_end_pkg::ADDR_W-1:0] issue_pc;
   logic [front_end_pkg::INSN_W-1:0] issue_insn;
   front_end_pkg::opcode_e           issue_op;
   logic                             except_valid;
   logic [front_end_pkg::ADDR_W-1:0] except_pc;

   // program memory and per-word bus error flags
   logic [31:0] mem [0:1023];
   bit          fault_map [0:1023];
   int          fixed_lat = 0;
   bit          busy = 1'b0;
   int          wait_left = 0;
   // stall span generator
   bit          stall_en = 1'b0;
   int          stall_left = 0;
   // expected strobes in order, exception flag, pc and word
   bit          exp_exc [$];
   logic [31:0] exp_pc [$];
   logic [31:0] exp_word [$];
   bit          checking = 1'b0;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          cycle_count = 0;

   front_end_top UUT (
      .clk(clk), .rst(rst),
      .ibus_req_o(ibus_req), .ibus_adr_o(ibus_adr), .ibus_ack_i(ibus_ack),
      .ibus_err_i(ibus_err), .ibus_dat_i(ibus_dat), .stall_i(stall),
      .issue_valid_o(issue_valid), .issue_pc_o(issue_pc), .issue_insn_o(issue_insn),
      .issue_op_o(issue_op), .except_valid_o(except_valid), .except_pc_o(except_pc)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ibus slave, answers once per request after the chosen latency
   always @(posedge clk)
   begin
      if (rst)
      begin
         ibus_ack <= 1'b0;
         ibus_err <= 1'b0;
         busy = 1'b0;
      end
      else
      begin
         ibus_ack <= 1'b0;
         ibus_err <= 1'b0;
         if (!ibus_req)
            busy = 1'b0;
         else if (!busy && !ibus_ack && !ibus_err)
         begin
            busy = 1'b1;
            wait_left = (fixed_lat != 0) ? fixed_lat : int'($urandom_range(1, 3));
         end
         if (busy)
         begin
            wait_left = wait_left - 1;
            if (wait_left == 0)
            begin
               busy = 1'b0;
               ibus_dat <= mem[ibus_adr[11:2]];
               if (fault_map[ibus_adr[11:2]])
                  ibus_err <= 1'b1;
               else
                  ibus_ack <= 1'b1;
            end
         end
      end
   end

   // random stall spans of 1 to 6 cycles
   always @(posedge clk)
   begin
      if (rst || !stall_en)
         stall <= 1'b0;
      else if (stall_left != 0)
      begin
         stall_left = stall_left - 1;
         stall <= 1'b1;
      end
      else
      begin
         stall <= 1'b0;
         if ($urandom_range(0, 3) == 0)
            stall_left = int'($urandom_range(1, 6));
      end
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("run stopped after %0d cycles, a test never finished", cycle_count);
         $display("Errors found");
         $finish;
      end
   end

   always @(posedge clk)
   begin
      if (!rst && checking && (issue_valid || except_valid))
         check_event();
   end

   // opcode class by the major opcode
   function automatic front_end_pkg::opcode_e expected_class(input logic [31:0] w);
      if (w[31:26] == 6'h00)
         return front_end_pkg::OP_J;
      else if (w[31:26] == 6'h05)
         return front_end_pkg::OP_NOP;
      return front_end_pkg::OP_OTHER;
   endfunction

   // never a jump, every fifth word a nop
   function automatic logic [31:0] random_word(input int i);
      logic [31:0] w;
      w = $urandom;
      if (i % 5 == 3)
         w[31:26] = 6'h05;
      else if (w[31:26] == 6'h00 || w[31:26] == 6'h05)
         w[31:26] = 6'h27;
      return w;
   endfunction

   function automatic logic [31:0] jump_word(input logic [31:0] from, input logic [31:0] to);
      logic [31:0] d;
      d = to - from;
      return {6'h00, d[27:2]};
   endfunction

   task automatic show_mismatch(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
      errors++;
      $display("Fail %0t %s got %h expected %h", $time, sig, got, exp);
   endtask

   task automatic check_event();
      bit          e;
      logic [31:0] pc;
      logic [31:0] w;
      if (exp_pc.size() == 0)
      begin
         errors++;
         $display("strobe at %0t with no event left to expect", $time);
         return;
      end
      e = exp_exc.pop_front();
      pc = exp_pc.pop_front();
      w = exp_word.pop_front();
      if (except_valid != e)
         show_mismatch("except_valid_o", 32'(except_valid), 32'(e));
      else if (e && except_pc != pc)
         show_mismatch("except_pc_o", except_pc, pc);
      else if (!e)
      begin
         if (issue_pc != pc)
            show_mismatch("issue_pc_o", issue_pc, pc);
         if (issue_insn != w)
            show_mismatch("issue_insn_o", issue_insn, w);
         if (issue_op != expected_class(w))
            show_mismatch("issue_op_o", 32'(issue_op), 32'(expected_class(w)));
      end
      if (exp_pc.size() == 0)
         checking = 1'b0;
   endtask

   task automatic fill_memory();
      for (int i = 0; i < 1024; i++)
      begin
         mem[i] = {6'h27, 10'(i), 6'h15, 10'(i)};
         fault_map[i] = 1'b0;
      end
   endtask

   task automatic put_word(input logic [31:0] addr, input logic [31:0] w);
      mem[addr[11:2]] = w;
   endtask

   // reference walk: +4, one delay slot after l.j, then the target,
   // a faulting word turns into an exception and a restart at the vector
   task automatic build_expected(input int n);
      logic [31:0] pc;
      logic [31:0] w;
      logic [31:0] target;
      bit          in_slot;
      pc = front_end_pkg::RESET_PC;
      target = '0;
      in_slot = 1'b0;
      exp_exc.delete();
      exp_pc.delete();
      exp_word.delete();
      for (int k = 0; k < n; k++)
      begin
         w = mem[pc[11:2]];
         exp_exc.push_back(fault_map[pc[11:2]]);
         exp_pc.push_back(pc);
         exp_word.push_back(w);
         if (fault_map[pc[11:2]])
         begin
            pc = front_end_pkg::EXCEPT_VEC;
            in_slot = 1'b0;
         end
         else if (in_slot)
         begin
            pc = target;
            in_slot = 1'b0;
         end
         else
         begin
            if (w[31:26] == 6'h00)
            begin
               target = pc + {{4{w[25]}}, w[25:0], 2'b00};
               in_slot = 1'b1;
            end
            pc = pc + 32'd4;
         end
      end
   endtask

   task automatic apply_reset();
      rst <= 1'b1;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
   endtask

   task automatic finish_test(input string name, input int start_err);
      tests_run++;
      if (errors == start_err)
         $display("test %s: passed", name);
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - start_err);
      end
   endtask

   // reset, then compare strobes until n events are seen or time runs out
   task automatic run_program(input string name, input int lat, input int n);
      int start_err;
      int cycles;
      start_err = errors;
      fixed_lat = lat;
      build_expected(n);
      apply_reset();
      checking = 1'b1;
      cycles = 0;
      while (checking && cycles < 30 * n)
      begin
         @(posedge clk);
         cycles++;
      end
      if (checking)
      begin
         errors++;
         $display("test %s timed out with %0d events never seen", name, exp_pc.size());
         checking = 1'b0;
      end
      finish_test(name, start_err);
   endtask

   task automatic test_reset_fetch();
      int start_err;
      int cycles;
      start_err = errors;
      fixed_lat = 0;
      fill_memory();
      apply_reset();
      cycles = 0;
      while (!ibus_req && cycles < 8)
      begin
         @(posedge clk);
         if (issue_valid || except_valid)
         begin
            errors++;
            $display("strobe at %0t before the first ibus request", $time);
         end
         cycles++;
      end
      if (!ibus_req)
      begin
         errors++;
         $display("no ibus request within 8 cycles of reset");
      end
      else if (ibus_adr != front_end_pkg::RESET_PC)
         show_mismatch("ibus_adr_o", ibus_adr, front_end_pkg::RESET_PC);
      finish_test("reset fetch", start_err);
   endtask

   task automatic test_straight_line();
      fill_memory();
      for (int i = 0; i < 20; i++)
         put_word(front_end_pkg::RESET_PC + 32'(4 * i), random_word(i));
      run_program("straight line", 0, 20);
   endtask

   // forward jump over 0x10c, then a backward jump that loops
   task automatic test_jumps();
      fill_memory();
      for (int i = 0; i < 12; i++)
         put_word(front_end_pkg::RESET_PC + 32'(4 * i), random_word(i));
      put_word(32'h104, jump_word(32'h104, 32'h120));
      put_word(32'h128, jump_word(32'h128, 32'h110));
      run_program("jumps", 0, 24);
   endtask

   task automatic test_stall();
      fill_memory();
      for (int i = 0; i < 24; i++)
         put_word(front_end_pkg::RESET_PC + 32'(4 * i), random_word(i));
      stall_en = 1'b1;
      run_program("stall", 0, 24);
      stall_en = 1'b0;
   endtask

   task automatic test_bus_error();
      fill_memory();
      for (int i = 0; i < 8; i++)
         put_word(front_end_pkg::RESET_PC + 32'(4 * i), random_word(i));
      for (int i = 0; i < 6; i++)
         put_word(front_end_pkg::EXCEPT_VEC + 32'(4 * i), random_word(i + 1));
      fault_map[32'h10c >> 2] = 1'b1;
      run_program("bus error", 2, 10);
   endtask

   // the fault in the delay slot wins over the jump target 0x140
   task automatic test_slot_fault();
      fill_memory();
      put_word(32'h100, random_word(0));
      put_word(32'h104, jump_word(32'h104, 32'h140));
      put_word(32'h140, random_word(1));
      for (int i = 0; i < 4; i++)
         put_word(front_end_pkg::EXCEPT_VEC + 32'(4 * i), random_word(i + 2));
      fault_map[32'h108 >> 2] = 1'b1;
      run_program("delay slot fault", 1, 7);
   endtask

   initial
   begin
      void'($urandom(32'h6bfb4c44));
      test_reset_fetch();
      test_straight_line();
      test_jumps();
      test_stall();
      test_bus_error();
      test_slot_fault();
      $display("tests %0d, failed tests %0d, failed checks %0d",
               tests_run, tests_failed, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
common/front_end_pkg.sv
fetch/fetch_unit.sv
logic/insn_decode.sv
logic/pipe_control.sv
logic/front_end_top.sv
tests/front_end_checker.sv
tests/tb_front_end.sv

//--- Makefile
# Verilator build and run of the front end testbench

SRCS := $(shell cat list.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_front_end: list.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_front_end -f list.f

# pass only if the run printed the pass line
run: obj_dir/Vtb_front_end
	@out="$$(./obj_dir/Vtb_front_end)"; echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf obj_dir
